/* src.f */
rtl/rv_isa_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/word_ram.sv
rtl/pc_unit.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/mem_writeback.sv
rtl/rv_core_top.sv
tb/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/core_ctrl_pkg.sv
  - rtl/word_ram.sv
  - rtl/pc_unit.sv
  - rtl/inst_decoder.sv
  - rtl/reg_file.sv
  - rtl/exec_unit.sv
  - rtl/mem_writeback.sv
  - rtl/rv_core_top.sv
  - target: test
    files:
      - tb/tb_rv_core.sv

/* tb/core_input.txt */
# P <word address> <instruction>   W <rd> <value>   H <halt pc>
# All fields are hex, text after the fields is ignored
P 00 00500093 addi x1,x0,5
P 01 ffd00113 addi x2,x0,-3
P 02 002081b3 add x3,x1,x2
P 03 40110233 sub x4,x2,x1
P 04 0020f2b3 and x5,x1,x2
P 05 0020e333 or x6,x1,x2
P 06 0020c3b3 xor x7,x1,x2
P 07 00112433 slt x8,x2,x1
P 08 001094b3 sll x9,x1,x1
P 09 00115533 srl x10,x2,x1
P 0a 123455b7 lui x11,0x12345
P 0b 00001617 auipc x12,1
P 0c 00703823 sd x7,16(x0)
P 0d 01003683 ld x13,16(x0)
P 0e 00708013 addi x0,x1,7
P 0f 00108463 beq x1,x1,+8 taken
P 10 00100713 skipped
P 11 00109463 bne x1,x1,+8 not taken
P 12 00200713 addi x14,x0,2
P 13 00114463 blt x2,x1,+8 taken
P 14 00100793 skipped
P 15 00115463 bge x2,x1,+8 not taken
P 16 00300793 addi x15,x0,3
P 17 00111463 bne x2,x1,+8 taken
P 18 00100a13 skipped
P 19 0020d463 bge x1,x2,+8 taken
P 1a 00200a13 skipped
P 1b 00c0086f jal x16,+12
P 1c 00100893 skipped
P 1d 00200893 skipped
P 1e 01580967 jalr x18,0x15(x16) lands on 0x84
P 1f 00100993 skipped
P 20 00200993 skipped
P 21 00900993 addi x19,x0,9
P 22 00100073 ebreak
W 01 0000000000000005
W 02 fffffffffffffffd
W 03 0000000000000002
W 04 fffffffffffffff8
W 05 0000000000000005
W 06 fffffffffffffffd
W 07 fffffffffffffff8
W 08 0000000000000001
W 09 00000000000000a0
W 0a 07ffffffffffffff
W 0b 0000000012345000
W 0c 000000000000102c
W 0d fffffffffffffff8
W 0e 0000000000000002
W 0f 0000000000000003
W 10 0000000000000070
W 12 000000000000007c
W 13 0000000000000009
H 0000000000000088

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam int                IMEM_DEPTH  = 256;
  localparam int                DMEM_DEPTH  = 256;
  localparam int                IMEM_AW     = $clog2(IMEM_DEPTH);
  localparam rv_isa_pkg::xlen_t RESET_PC    = 64'h0;
  localparam int                RUN_LIMIT   = 2000;
  localparam int                QUIET_LIMIT = 20;

  logic                 clk;
  logic                 arst_n;
  logic                 run;
  logic                 imem_we;
  logic [IMEM_AW-1:0]   imem_addr;
  rv_isa_pkg::inst_t    imem_wdata;
  rv_isa_pkg::xlen_t    pc;
  logic                 wb_valid;
  rv_isa_pkg::reg_idx_t wb_addr;
  rv_isa_pkg::xlen_t    wb_data;
  logic                 halt;

  logic [IMEM_AW-1:0]   prog_addr [$];
  rv_isa_pkg::inst_t    prog_word [$];
  rv_isa_pkg::reg_idx_t exp_rd [$];
  rv_isa_pkg::xlen_t    exp_val [$];
  rv_isa_pkg::xlen_t    exp_halt_pc;
  logic                 input_ok;
  int                   value_errors;
  int                   other_errors;

  rv_core_top #(
    .IMEM_DEPTH (IMEM_DEPTH),
    .DMEM_DEPTH (DMEM_DEPTH),
    .RESET_PC   (RESET_PC)
  ) i_dut (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .run_i        (run),
    .imem_we_i    (imem_we),
    .imem_addr_i  (imem_addr),
    .imem_wdata_i (imem_wdata),
    .pc_o         (pc),
    .wb_valid_o   (wb_valid),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data),
    .halt_o       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ******************************
  // Compare tasks
  // ******************************
  task automatic check_wb(input rv_isa_pkg::reg_idx_t got_rd, input rv_isa_pkg::xlen_t got_val,
                          input rv_isa_pkg::reg_idx_t want_rd, input rv_isa_pkg::xlen_t want_val);
    if (got_rd !== want_rd) begin
      $display("ERR wb_addr_o: got %h, expected %h", got_rd, want_rd);
      value_errors++;
    end
    if (got_val !== want_val) begin
      $display("ERR wb_data_o: got %h, expected %h (rd %h)", got_val, want_val, want_rd);
      value_errors++;
    end
  endtask

  task automatic check_halt(input logic got_halt, input rv_isa_pkg::xlen_t got_pc,
                            input rv_isa_pkg::xlen_t want_pc);
    if (got_halt !== 1'b1) begin
      $display("ERR halt_o: got %h, expected 1", got_halt);
      value_errors++;
    end
    if (got_pc !== want_pc) begin
      $display("ERR pc_o: got %h, expected %h", got_pc, want_pc);
      value_errors++;
    end
  endtask

  // ******************************
  // Stimulus file and program load
  // ******************************
  task automatic read_stimulus();
    int         fd;
    int         n;
    string      line;
    logic [7:0] tag;
    logic [63:0] a;
    logic [63:0] b;
    logic       seen_halt;
    input_ok  = 1'b0;
    seen_halt = 1'b0;
    fd = $fopen("tb/core_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/core_input.txt for reading");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Blank lines and lines starting with # carry no data
      if (n > 1 && line.getc(0) != 8'h23) begin
        a = '0;
        b = '0;
        n = $sscanf(line, "%c %h %h", tag, a, b);
        case (tag)
          "P": begin
            prog_addr.push_back(a[IMEM_AW-1:0]);
            prog_word.push_back(b[31:0]);
          end
          "W": begin
            exp_rd.push_back(a[4:0]);
            exp_val.push_back(b);
          end
          "H": begin
            exp_halt_pc = a;
            seen_halt   = 1'b1;
          end
          default: begin
            $display("Unrecognized line in the stimulus file: %s", line);
            other_errors++;
          end
        endcase
      end
    end
    $fclose(fd);
    input_ok = seen_halt && (prog_word.size() > 0);
    if (!input_ok) begin
      $display("The stimulus file holds no program or no halt address");
      other_errors++;
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_word.size(); i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= prog_addr[i];
      imem_wdata <= prog_word[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  // ******************************
  // Run with random pauses
  // ******************************
  task automatic run_program();
    int                cycles;
    int                quiet;
    int                pause_left;
    logic              prev_run;
    rv_isa_pkg::xlen_t prev_pc;
    cycles     = 0;
    pause_left = 0;
    prev_run   = 1'b0;
    prev_pc    = RESET_PC;
    while (halt !== 1'b1 && cycles < RUN_LIMIT) begin
      @(posedge clk);
      if (pause_left > 0) begin
        run <= 1'b0;
        pause_left--;
      end else begin
        run <= 1'b1;
        if ($urandom % 6 == 0) begin
          pause_left = 1 + $urandom % 3;
        end
      end
      @(negedge clk);
      // A cycle with run_i low must leave the PC untouched at the next edge
      if (!prev_run && pc !== prev_pc) begin
        $display("ERR pc_o: got %h, expected %h while paused", pc, prev_pc);
        value_errors++;
      end
      if (!run && wb_valid !== 1'b0) begin
        $display("ERR wb_valid_o: got %h, expected 0 while paused", wb_valid);
        value_errors++;
      end
      if (run && wb_valid === 1'b1) begin
        if (exp_rd.size() == 0) begin
          $display("Register write to x%0d after the last expected write", wb_addr);
          other_errors++;
        end else begin
          check_wb(wb_addr, wb_data, exp_rd.pop_front(), exp_val.pop_front());
        end
      end
      prev_run = run;
      prev_pc  = pc;
      cycles++;
    end
    if (halt !== 1'b1) begin
      $display("Timeout: the core did not halt within %0d cycles", RUN_LIMIT);
      other_errors++;
    end else begin
      check_halt(halt, pc, exp_halt_pc);
      if (exp_rd.size() != 0) begin
        $display("The core halted with %0d expected writes not seen", exp_rd.size());
        other_errors++;
      end
      quiet = 0;
      while (quiet < QUIET_LIMIT) begin
        @(posedge clk);
        run <= 1'b1;
        @(negedge clk);
        if (wb_valid !== 1'b0) begin
          $display("ERR wb_valid_o: got %h, expected 0 after halt", wb_valid);
          value_errors++;
        end
        check_halt(halt, pc, exp_halt_pc);
        quiet++;
      end
    end
  endtask

  initial begin
    void'($urandom(40));
    value_errors = 0;
    other_errors = 0;
    arst_n       = 1'b0;
    run          = 1'b0;
    imem_we      = 1'b0;
    imem_addr    = '0;
    imem_wdata   = '0;
    read_stimulus();
    if (input_ok) begin
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      load_program();
      run_program();
    end
    $display("Error count: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* rtl/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
  parameter int                IMEM_DEPTH = 256,
  parameter int                DMEM_DEPTH = 256,
  parameter rv_isa_pkg::xlen_t RESET_PC   = '0
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          run_i,
  input  logic                          imem_we_i,
  input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
  input  rv_isa_pkg::inst_t             imem_wdata_i,
  output rv_isa_pkg::xlen_t             pc_o,
  output logic                          wb_valid_o,
  output rv_isa_pkg::reg_idx_t          wb_addr_o,
  output rv_isa_pkg::xlen_t             wb_data_o,
  output logic                          halt_o
);

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  rv_isa_pkg::xlen_t         pc;
  rv_isa_pkg::xlen_t         pc4;
  logic                      active;
  rv_isa_pkg::inst_t         inst;
  rv_isa_pkg::reg_idx_t      rs1;
  rv_isa_pkg::reg_idx_t      rs2;
  rv_isa_pkg::reg_idx_t      rd;
  rv_isa_pkg::xlen_t         imm;
  core_ctrl_pkg::alu_op_e    alu_op;
  core_ctrl_pkg::src_a_sel_e src_a_sel;
  core_ctrl_pkg::src_b_sel_e src_b_sel;
  core_ctrl_pkg::br_op_e     br_op;
  core_ctrl_pkg::wb_sel_e    wb_sel;
  logic                      reg_wen;
  logic                      mem_wen;
  logic                      mem_ren;
  logic                      is_ebreak;
  rv_isa_pkg::xlen_t         rdata1;
  rv_isa_pkg::xlen_t         rdata2;
  rv_isa_pkg::xlen_t         alu_result;
  logic                      redirect;
  rv_isa_pkg::xlen_t         target;
  rv_isa_pkg::xlen_t         wb_data;

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) i_pc_unit (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .run_i       (run_i),
    .is_ebreak_i (is_ebreak),
    .redirect_i  (redirect),
    .target_i    (target),
    .pc_o        (pc),
    .pc4_o       (pc4),
    .active_o    (active),
    .halt_o      (halt_o)
  );

  word_ram #(
    .word_t (rv_isa_pkg::inst_t),
    .DEPTH  (IMEM_DEPTH)
  ) i_imem (
    .clk_i   (clk_i),
    .we_i    (imem_we_i),
    .waddr_i (imem_addr_i),
    .wdata_i (imem_wdata_i),
    .raddr_i (pc[IMEM_AW+1:2]),
    .rdata_o (inst)
  );

  inst_decoder i_decoder (
    .inst_i      (inst),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd),
    .imm_o       (imm),
    .alu_op_o    (alu_op),
    .src_a_sel_o (src_a_sel),
    .src_b_sel_o (src_b_sel),
    .br_op_o     (br_op),
    .reg_wen_o   (reg_wen),
    .mem_wen_o   (mem_wen),
    .mem_ren_o   (mem_ren),
    .wb_sel_o    (wb_sel),
    .is_ebreak_o (is_ebreak)
  );

  // Register writes only retire in an active cycle
  reg_file i_reg_file (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wen_i    (reg_wen & active),
    .waddr_i  (rd),
    .wdata_i  (wb_data),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  exec_unit i_exec_unit (
    .pc_i         (pc),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .imm_i        (imm),
    .alu_op_i     (alu_op),
    .src_a_sel_i  (src_a_sel),
    .src_b_sel_i  (src_b_sel),
    .br_op_i      (br_op),
    .alu_result_o (alu_result),
    .redirect_o   (redirect),
    .target_o     (target)
  );

  mem_writeback #(
    .DEPTH (DMEM_DEPTH)
  ) i_mem_wb (
    .clk_i        (clk_i),
    .mem_wen_i    (mem_wen & active),
    .mem_ren_i    (mem_ren),
    .addr_i       (alu_result),
    .store_data_i (rdata2),
    .alu_result_i (alu_result),
    .pc4_i        (pc4),
    .wb_sel_i     (wb_sel),
    .wb_data_o    (wb_data)
  );

  assign pc_o       = pc;
  assign wb_valid_o = reg_wen & active;
  assign wb_addr_o  = rd;
  assign wb_data_o  = wb_data;

endmodule

/* rtl/mem_writeback.sv */
`timescale 1ns/1ps

module mem_writeback #(
  parameter int DEPTH = 256
) (
  input  logic                   clk_i,
  input  logic                   mem_wen_i,
  input  logic                   mem_ren_i,
  input  rv_isa_pkg::xlen_t      addr_i,
  input  rv_isa_pkg::xlen_t      store_data_i,
  input  rv_isa_pkg::xlen_t      alu_result_i,
  input  rv_isa_pkg::xlen_t      pc4_i,
  input  core_ctrl_pkg::wb_sel_e wb_sel_i,
  output rv_isa_pkg::xlen_t      wb_data_o
);

  localparam int AW = $clog2(DEPTH);

  logic [AW-1:0]     word_idx;
  rv_isa_pkg::xlen_t ram_rdata;
  rv_isa_pkg::xlen_t load_data;

  // The doubleword index drops the low three byte bits
  assign word_idx = addr_i[AW+2:3];

  word_ram #(
    .word_t (rv_isa_pkg::xlen_t),
    .DEPTH  (DEPTH)
  ) i_dmem (
    .clk_i   (clk_i),
    .we_i    (mem_wen_i),
    .waddr_i (word_idx),
    .wdata_i (store_data_i),
    .raddr_i (word_idx),
    .rdata_o (ram_rdata)
  );

  assign load_data = mem_ren_i ? ram_rdata : '0;

  always_comb begin
    case (wb_sel_i)
      core_ctrl_pkg::WB_MEM: wb_data_o = load_data;
      core_ctrl_pkg::WB_PC4: wb_data_o = pc4_i;
      default:               wb_data_o = alu_result_i;
    endcase
  end

endmodule

/* rtl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
  input  rv_isa_pkg::xlen_t         pc_i,
  input  rv_isa_pkg::xlen_t         rdata1_i,
  input  rv_isa_pkg::xlen_t         rdata2_i,
  input  rv_isa_pkg::xlen_t         imm_i,
  input  core_ctrl_pkg::alu_op_e    alu_op_i,
  input  core_ctrl_pkg::src_a_sel_e src_a_sel_i,
  input  core_ctrl_pkg::src_b_sel_e src_b_sel_i,
  input  core_ctrl_pkg::br_op_e     br_op_i,
  output rv_isa_pkg::xlen_t         alu_result_o,
  output logic                      redirect_o,
  output rv_isa_pkg::xlen_t         target_o
);

  rv_isa_pkg::xlen_t op_a;
  rv_isa_pkg::xlen_t op_b;
  logic [5:0]        shamt;
  logic              is_eq;
  logic              is_lt;

  // ******************************
  // Operand select and ALU
  // ******************************
  always_comb begin
    case (src_a_sel_i)
      core_ctrl_pkg::SRC_A_PC:   op_a = pc_i;
      core_ctrl_pkg::SRC_A_ZERO: op_a = '0;
      default:                   op_a = rdata1_i;
    endcase
  end

  assign op_b  = (src_b_sel_i == core_ctrl_pkg::SRC_B_IMM) ? imm_i : rdata2_i;
  assign shamt = op_b[5:0];

  always_comb begin
    case (alu_op_i)
      core_ctrl_pkg::ALU_SUB:    alu_result_o = op_a - op_b;
      core_ctrl_pkg::ALU_AND:    alu_result_o = op_a & op_b;
      core_ctrl_pkg::ALU_OR:     alu_result_o = op_a | op_b;
      core_ctrl_pkg::ALU_XOR:    alu_result_o = op_a ^ op_b;
      core_ctrl_pkg::ALU_SLT:    alu_result_o = {63'b0, $signed(op_a) < $signed(op_b)};
      core_ctrl_pkg::ALU_SLL:    alu_result_o = op_a << shamt;
      core_ctrl_pkg::ALU_SRL:    alu_result_o = op_a >> shamt;
      core_ctrl_pkg::ALU_PASS_B: alu_result_o = op_b;
      default:                   alu_result_o = op_a + op_b;
    endcase
  end

  // ******************************
  // Branch decision and target
  // ******************************
  assign is_eq = (rdata1_i == rdata2_i);
  assign is_lt = ($signed(rdata1_i) < $signed(rdata2_i));

  always_comb begin
    case (br_op_i)
      core_ctrl_pkg::BR_EQ:   redirect_o = is_eq;
      core_ctrl_pkg::BR_NE:   redirect_o = ~is_eq;
      core_ctrl_pkg::BR_LT:   redirect_o = is_lt;
      core_ctrl_pkg::BR_GE:   redirect_o = ~is_lt;
      core_ctrl_pkg::BR_JAL:  redirect_o = 1'b1;
      core_ctrl_pkg::BR_JALR: redirect_o = 1'b1;
      default:                redirect_o = 1'b0;
    endcase
  end

  // JALR clears bit 0 of the sum as the ISA requires
  assign target_o = (br_op_i == core_ctrl_pkg::BR_JALR) ?
                    ((rdata1_i + imm_i) & ~64'd1) : (pc_i + imm_i);

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 wen_i,
  input  rv_isa_pkg::reg_idx_t waddr_i,
  input  rv_isa_pkg::xlen_t    wdata_i,
  input  rv_isa_pkg::reg_idx_t raddr1_i,
  input  rv_isa_pkg::reg_idx_t raddr2_i,
  output rv_isa_pkg::xlen_t    rdata1_o,
  output rv_isa_pkg::xlen_t    rdata2_o
);

  // Only x1 to x31 are stored
  rv_isa_pkg::xlen_t regs_q [1:31];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wen_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs_q[raddr2_i];

endmodule

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  rv_isa_pkg::inst_t         inst_i,
  output rv_isa_pkg::reg_idx_t      rs1_o,
  output rv_isa_pkg::reg_idx_t      rs2_o,
  output rv_isa_pkg::reg_idx_t      rd_o,
  output rv_isa_pkg::xlen_t         imm_o,
  output core_ctrl_pkg::alu_op_e    alu_op_o,
  output core_ctrl_pkg::src_a_sel_e src_a_sel_o,
  output core_ctrl_pkg::src_b_sel_e src_b_sel_o,
  output core_ctrl_pkg::br_op_e     br_op_o,
  output logic                      reg_wen_o,
  output logic                      mem_wen_o,
  output logic                      mem_ren_o,
  output core_ctrl_pkg::wb_sel_e    wb_sel_o,
  output logic                      is_ebreak_o
);

  logic [6:0]        opcode;
  logic [2:0]        func3;
  logic [6:0]        func7;
  rv_isa_pkg::xlen_t imm_i_type;
  rv_isa_pkg::xlen_t imm_s_type;
  rv_isa_pkg::xlen_t imm_b_type;
  rv_isa_pkg::xlen_t imm_u_type;
  rv_isa_pkg::xlen_t imm_j_type;
  logic              rd_wen;

  assign opcode = inst_i[6:0];
  assign func3  = inst_i[14:12];
  assign func7  = inst_i[31:25];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];
  assign rd_o   = inst_i[11:7];

  // ******************************
  // Immediate formats
  // ******************************
  assign imm_i_type = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_type = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
  assign imm_u_type = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j_type = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                       inst_i[30:21], 1'b0};

  // ******************************
  // Control
  // ******************************
  always_comb begin
    imm_o       = '0;
    alu_op_o    = core_ctrl_pkg::ALU_ADD;
    src_a_sel_o = core_ctrl_pkg::SRC_A_REG;
    src_b_sel_o = core_ctrl_pkg::SRC_B_REG;
    br_op_o     = core_ctrl_pkg::BR_NONE;
    wb_sel_o    = core_ctrl_pkg::WB_ALU;
    rd_wen      = 1'b0;
    mem_wen_o   = 1'b0;
    mem_ren_o   = 1'b0;
    is_ebreak_o = 1'b0;
    case (opcode)
      rv_isa_pkg::OPC_OP_IMM: begin
        if (func3 == rv_isa_pkg::F3_ADD_SUB) begin
          imm_o       = imm_i_type;
          src_b_sel_o = core_ctrl_pkg::SRC_B_IMM;
          rd_wen      = 1'b1;
        end
      end
      rv_isa_pkg::OPC_OP: begin
        rd_wen = (func7 == rv_isa_pkg::F7_BASE);
        case (func3)
          rv_isa_pkg::F3_ADD_SUB: begin
            if (func7 == rv_isa_pkg::F7_SUB) begin
              alu_op_o = core_ctrl_pkg::ALU_SUB;
              rd_wen   = 1'b1;
            end
          end
          rv_isa_pkg::F3_SLL: alu_op_o = core_ctrl_pkg::ALU_SLL;
          rv_isa_pkg::F3_SLT: alu_op_o = core_ctrl_pkg::ALU_SLT;
          rv_isa_pkg::F3_XOR: alu_op_o = core_ctrl_pkg::ALU_XOR;
          rv_isa_pkg::F3_SRL: alu_op_o = core_ctrl_pkg::ALU_SRL;
          rv_isa_pkg::F3_OR:  alu_op_o = core_ctrl_pkg::ALU_OR;
          rv_isa_pkg::F3_AND: alu_op_o = core_ctrl_pkg::ALU_AND;
          default:            rd_wen   = 1'b0;
        endcase
      end
      rv_isa_pkg::OPC_LUI: begin
        imm_o       = imm_u_type;
        alu_op_o    = core_ctrl_pkg::ALU_PASS_B;
        src_a_sel_o = core_ctrl_pkg::SRC_A_ZERO;
        src_b_sel_o = core_ctrl_pkg::SRC_B_IMM;
        rd_wen      = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        imm_o       = imm_u_type;
        src_a_sel_o = core_ctrl_pkg::SRC_A_PC;
        src_b_sel_o = core_ctrl_pkg::SRC_B_IMM;
        rd_wen      = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        imm_o    = imm_j_type;
        br_op_o  = core_ctrl_pkg::BR_JAL;
        wb_sel_o = core_ctrl_pkg::WB_PC4;
        rd_wen   = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        if (func3 == rv_isa_pkg::F3_JALR) begin
          imm_o    = imm_i_type;
          br_op_o  = core_ctrl_pkg::BR_JALR;
          wb_sel_o = core_ctrl_pkg::WB_PC4;
          rd_wen   = 1'b1;
        end
      end
      rv_isa_pkg::OPC_BRANCH: begin
        imm_o = imm_b_type;
        case (func3)
          rv_isa_pkg::F3_BEQ: br_op_o = core_ctrl_pkg::BR_EQ;
          rv_isa_pkg::F3_BNE: br_op_o = core_ctrl_pkg::BR_NE;
          rv_isa_pkg::F3_BLT: br_op_o = core_ctrl_pkg::BR_LT;
          rv_isa_pkg::F3_BGE: br_op_o = core_ctrl_pkg::BR_GE;
          default:            br_op_o = core_ctrl_pkg::BR_NONE;
        endcase
      end
      rv_isa_pkg::OPC_LOAD: begin
        if (func3 == rv_isa_pkg::F3_LD) begin
          imm_o       = imm_i_type;
          src_b_sel_o = core_ctrl_pkg::SRC_B_IMM;
          mem_ren_o   = 1'b1;
          wb_sel_o    = core_ctrl_pkg::WB_MEM;
          rd_wen      = 1'b1;
        end
      end
      rv_isa_pkg::OPC_STORE: begin
        if (func3 == rv_isa_pkg::F3_SD) begin
          imm_o       = imm_s_type;
          src_b_sel_o = core_ctrl_pkg::SRC_B_IMM;
          mem_wen_o   = 1'b1;
        end
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        is_ebreak_o = (inst_i == rv_isa_pkg::EBREAK_INST);
      end
      default: ;
    endcase
  end

  // A write to x0 is not a write at all
  assign reg_wen_o = rd_wen & (rd_o != 5'd0);

endmodule

/* rtl/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit #(
  parameter rv_isa_pkg::xlen_t RESET_PC = '0
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              run_i,
  input  logic              is_ebreak_i,
  input  logic              redirect_i,
  input  rv_isa_pkg::xlen_t target_i,
  output rv_isa_pkg::xlen_t pc_o,
  output rv_isa_pkg::xlen_t pc4_o,
  output logic              active_o,
  output logic              halt_o
);

  rv_isa_pkg::xlen_t pc_q;
  rv_isa_pkg::xlen_t next_pc;
  logic              halted_q;

  assign active_o = run_i & ~halted_q;
  assign pc4_o    = pc_q + 64'd4;
  assign next_pc  = redirect_i ? target_i : pc4_o;

  // On EBREAK the PC is left on the EBREAK itself
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q     <= RESET_PC;
      halted_q <= 1'b0;
    end else if (active_o) begin
      if (is_ebreak_i) begin
        halted_q <= 1'b1;
      end else begin
        pc_q <= next_pc;
      end
    end
  end

  assign pc_o   = pc_q;
  assign halt_o = halted_q;

endmodule

/* rtl/word_ram.sv */
`timescale 1ns/1ps

module word_ram #(
  parameter type word_t = logic [31:0],
  parameter int  DEPTH  = 256
) (
  input  logic                     clk_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  word_t                    wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output word_t                    rdata_o
);

  word_t mem [DEPTH];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Read is asynchronous so the core sees the word in the same cycle
  assign rdata_o = mem[raddr_i];

endmodule

/* rtl/core_ctrl_pkg.sv */
package core_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLL    = 4'd6,
    ALU_SRL    = 4'd7,
    ALU_PASS_B = 4'd8
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_A_REG  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2
  } src_a_sel_e;

  typedef enum logic {
    SRC_B_REG = 1'b0,
    SRC_B_IMM = 1'b1
  } src_b_sel_e;

  // JAL and JALR always redirect, the others only when the compare holds
  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_EQ   = 3'd1,
    BR_NE   = 3'd2,
    BR_LT   = 3'd3,
    BR_GE   = 3'd4,
    BR_JAL  = 3'd5,
    BR_JALR = 3'd6
  } br_op_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_e;

endpackage

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // ******************************
  // Major opcodes
  // ******************************
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ******************************
  // Function fields
  // ******************************
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_BLT     = 3'b100;
  localparam logic [2:0] F3_BGE     = 3'b101;
  localparam logic [2:0] F3_JALR    = 3'b000;
  localparam logic [2:0] F3_LD      = 3'b011;
  localparam logic [2:0] F3_SD      = 3'b011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  localparam inst_t EBREAK_INST = 32'h0010_0073;

endpackage
